// File: verification/gat_attn_cases.txt
// Record line: header 1 0 <id:2><count:2>0000, then feature words 0 0 <f3 f2 f1 f0>
// Result line: 2 <id:2> <edge count:2> <max score, 20-bit sign extended:5>
1001030000 0001020304 000A000500 00FF10FE20
2010300023
1002020000 0000100010 0000050001
20202FFFFF
1003000000
20300E0000
1004040000 007F7F7F7F 0080808080 007F807F80 0001000000
20404003FB
1005010000 0000000009
20501FFFFD
1006000000
20600E0000
1007050000 0000000100 0000000200 000000FF00 0003000000 0000000500
207050000F
1008020000 0080007F00 000000807F
208020007D

// File: gat_attn.f
verilog/gat_types_pkg.sv
verilog/gat_flow_pkg.sv
verilog/feat_stream_if.sv
verilog/sync_fifo.sv
verilog/feat_ingress.sv
verilog/edge_score_unit.sv
verilog/result_egress.sv
verilog/gat_attn_top.sv
verification/gat_attn_tb.sv

// File: Makefile
# Verilator build, run and lint for the edge-scoring stage

VERILATOR  ?= verilator
TOP        ?= gat_attn_tb
RTL_TOP    ?= gat_attn_top
FILELIST   ?= gat_attn.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "Simulation ended without a verdict"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/gat_attn_tb.sv
// Self-checking testbench for gat_attn_top; replays node records from the cases file under credit flow
`timescale 1ns/1ps

module gat_attn_tb import gat_types_pkg::*, gat_flow_pkg::*;;

  localparam int         IN_DEPTH    = 8;
  localparam int         OUT_DEPTH   = 4;
  localparam int         OUT_CREDITS = 4;
  localparam feat_word_t ATT_VEC     = 32'h02FF_03FE;
  localparam int         CASE_MAX    = 64;
  localparam int         HOLD_CYCLES = 120;      // Downstream withholds credits this long
  localparam string      CASE_FILE   = "verification/gat_attn_cases.txt";

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic        in_kind;
  logic [31:0] in_word;
  logic        in_credit;
  logic        out_valid;
  logic [7:0]  out_node_id;
  logic [7:0]  out_count;
  score_t      out_max_score;
  logic        out_credit;

  logic [39:0]  case_mem [CASE_MAX];
  logic [32:0]  stim_q [$];                      // Kind bit above the word
  node_result_t exp_q [$];
  logic         load_done = 1'b0;
  logic         run = 1'b0;
  logic [31:0]  rnd = 32'h434686ab;
  int n_words = 0;
  int n_exp = 0;
  int sent = 0;
  int up_credits = IN_DEPTH;                     // Credits the source still holds
  int pulse_cnt = 0;
  int valid_cnt = 0;
  int returned = 0;
  int ds_held = 0;                               // Results whose credit is not yet returned
  int got = 0;
  int cycle = 0;
  int gap = 0;
  int result_errs = 0;
  int credit_errs = 0;
  int other_errs = 0;

  gat_attn_top #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_DEPTH   (OUT_DEPTH),
    .OUT_CREDITS (OUT_CREDITS),
    .ATT_VEC     (ATT_VEC)
  ) dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_kind       (in_kind),
    .in_word       (in_word),
    .in_credit     (in_credit),
    .out_valid     (out_valid),
    .out_node_id   (out_node_id),
    .out_count     (out_count),
    .out_max_score (out_max_score),
    .out_credit    (out_credit)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Dot product with the attention vector, negative sums scaled by 1/8 rounding down
  function automatic score_t edge_score(input feat_word_t f);
    int acc;
    acc = 0;
    for (int k = 0; k < 4; k++) begin
      acc += int'(f[k]) * int'(ATT_VEC[k]);
    end
    if (acc < 0) begin
      acc = (acc - 7) / 8;                       // Floor division
    end
    return score_t'(acc);
  endfunction

  task automatic check_result(input node_result_t act, input node_result_t exp);
    if (act !== exp) begin
      result_errs++;
      $display("ERR %0t: result id=%0d count=%0d max=%0d, expected id=%0d count=%0d max=%0d",
               $time, act.node_id, act.edge_count, act.max_score,
               exp.node_id, exp.edge_count, exp.max_score);
    end
  endtask

  task automatic check_credit(input string what, input logic [credit_w-1:0] act,
                              input logic [credit_w-1:0] exp);
    if (act !== exp) begin
      credit_errs++;
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, act, exp);
    end
  endtask

  task automatic load_cases();
    logic [3:0]   tag;
    stream_word_u w;
    logic [7:0]   node;
    logic [7:0]   hdr_cnt;
    logic [7:0]   feat_cnt;
    score_t       best;
    score_t       s;
    node_result_t model;
    node_result_t listed;
    for (int i = 0; i < CASE_MAX; i++) begin
      case_mem[i] = {4'hF, 36'h0};               // End marker past the last entry
    end
    $readmemh(CASE_FILE, case_mem);
    node     = '0;
    hdr_cnt  = '0;
    feat_cnt = '0;
    best     = score_min;
    for (int i = 0; i < CASE_MAX; i++) begin
      tag = case_mem[i][39:36];
      w   = case_mem[i][31:0];
      if (tag == 4'h1) begin
        stim_q.push_back({kind_hdr, case_mem[i][31:0]});
        node     = w.hdr.node_id;
        hdr_cnt  = w.hdr.nbr_count;
        feat_cnt = '0;
        best     = score_min;
      end else if (tag == 4'h0) begin
        stim_q.push_back({kind_feat, case_mem[i][31:0]});
        s = edge_score(w.feat);
        feat_cnt++;
        if (s > best) begin
          best = s;
        end
      end else if (tag == 4'h2) begin
        model  = '{node_id: node, edge_count: hdr_cnt, max_score: best};
        listed = {case_mem[i][35:20], case_mem[i][17:0]};
        if (feat_cnt != hdr_cnt) begin
          other_errs++;
          $display("Node %0d has %0d feature words but its header says %0d",
                   node, feat_cnt, hdr_cnt);
        end
        if (listed !== model) begin
          other_errs++;
          $display("Case file expects max %0d for node %0d, reference model gives %0d",
                   listed.max_score, node, best);
        end
        exp_q.push_back(model);
      end else begin
        break;
      end
    end
    n_words = stim_q.size();
    n_exp   = exp_q.size();
    if (n_words == 0) begin
      other_errs++;
      $display("No stimulus words found in the case file");
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Source, result monitor and downstream credit model, all on the falling edge
  initial begin
    in_valid   = 1'b0;
    in_kind    = 1'b0;
    in_word    = '0;
    out_credit = 1'b0;
    forever begin
      @(negedge clk);
      if (run) begin
        if (in_credit) begin
          up_credits++;
          pulse_cnt++;
        end
        if (up_credits > IN_DEPTH) begin
          other_errs++;
          $display("Source received more credits than words it sent");
        end
        in_valid = 1'b0;
        if (sent < n_words && up_credits > 0) begin
          in_valid = 1'b1;
          in_kind  = stim_q[sent][32];
          in_word  = stim_q[sent][31:0];
          sent++;
          up_credits--;
        end
        if (out_valid) begin
          valid_cnt++;
          ds_held++;
          if (valid_cnt > OUT_CREDITS + returned) begin
            other_errs++;
            $display("Result %0d sent with only %0d credits granted", valid_cnt,
                     OUT_CREDITS + returned);
          end
          if (exp_q.size() == 0) begin
            other_errs++;
            $display("Unexpected extra result for node %0d", out_node_id);
          end else begin
            check_result({out_node_id, out_count, out_max_score}, exp_q.pop_front());
          end
          got++;
        end
        out_credit = 1'b0;
        if (cycle >= HOLD_CYCLES && ds_held > 0) begin
          if (gap == 0) begin
            out_credit = 1'b1;
            ds_held--;
            returned++;
            rnd = xorshift32(rnd);
            gap = int'(rnd % 32'd4);             // Zero to three idle cycles
          end else begin
            gap--;
          end
        end
        cycle++;
      end
    end
  end

  initial begin
    rst_n = 1'b0;
    load_cases();
    load_done = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    if (in_credit !== 1'b0 || out_valid !== 1'b0) begin
      other_errs++;
      $display("ERR %0t: in_credit is %b and out_valid is %b after reset, expected both low",
               $time, in_credit, out_valid);
    end
    check_credit("egress credits after reset", dut_i.u_egress.credits, credit_w'(OUT_CREDITS));
    @(posedge clk);
    run = 1'b1;
    while (got < n_exp || ds_held != 0 || sent < n_words) begin
      @(negedge clk);
    end
    repeat (20) @(negedge clk);                  // Late or repeated results show up here
    check_credit("upstream credit balance", credit_w'(up_credits), credit_w'(IN_DEPTH));
    check_credit("egress credit counter", dut_i.u_egress.credits, credit_w'(OUT_CREDITS));
    if (pulse_cnt != n_words) begin
      other_errs++;
      $display("ERR %0t: saw %0d in_credit pulses for %0d words sent",
               $time, pulse_cnt, n_words);
    end
    $display("Errors: result %0d, credit %0d, other %0d", result_errs, credit_errs, other_errs);
    if (result_errs + credit_errs + other_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    wait (load_done);
    repeat (n_words * 40 + 200) @(posedge clk);
    $display("Watchdog timeout with %0d of %0d results received and %0d of %0d words sent",
             got, n_exp, sent, n_words);
    $display("Test failed");
    $finish;
  end

endmodule

// File: verilog/gat_attn_top.sv
// Top level of the edge-scoring stage, credit-based stream in and per-node results out
`timescale 1ns/1ps

module gat_attn_top import gat_types_pkg::*; #(
  parameter int         IN_DEPTH    = 8,
  parameter int         OUT_DEPTH   = 4,
  parameter int         OUT_CREDITS = 4,
  parameter feat_word_t ATT_VEC     = 32'h02FF_03FE  // Feature 3 in the top byte
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  logic              in_kind,
  input  logic [word_w-1:0] in_word,
  output logic              in_credit,
  output logic              out_valid,
  output logic [7:0]        out_node_id,
  output logic [7:0]        out_count,
  output score_t            out_max_score,
  input  logic              out_credit
);

  feat_stream_if fs_if ();

  logic         res_push;
  node_result_t res_data;
  logic         res_space;

  feat_ingress #(.IN_DEPTH(IN_DEPTH)) u_ingress (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_kind   (in_kind),
    .in_word   (in_word),
    .in_credit (in_credit),
    .fs        (fs_if.src)
  );

  edge_score_unit #(.ATT_VEC(ATT_VEC)) u_score (
    .clk       (clk),
    .rst_n     (rst_n),
    .fs        (fs_if.dst),
    .res_push  (res_push),
    .res_data  (res_data),
    .res_space (res_space)
  );

  result_egress #(
    .OUT_DEPTH   (OUT_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) u_egress (
    .clk           (clk),
    .rst_n         (rst_n),
    .res_push      (res_push),
    .res_data      (res_data),
    .res_space     (res_space),
    .out_valid     (out_valid),
    .out_node_id   (out_node_id),
    .out_count     (out_count),
    .out_max_score (out_max_score),
    .out_credit    (out_credit)
  );

endmodule

// File: verilog/result_egress.sv
// Output side: queues node results and sends one per downstream credit held
`timescale 1ns/1ps

module result_egress import gat_types_pkg::*, gat_flow_pkg::*; #(
  parameter int OUT_DEPTH   = 4,
  parameter int OUT_CREDITS = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         res_push,
  input  node_result_t res_data,
  output logic         res_space,
  output logic         out_valid,
  output logic [7:0]   out_node_id,
  output logic [7:0]   out_count,
  output score_t       out_max_score,
  input  logic         out_credit
);

  localparam int RES_W = $bits(node_result_t);

  logic [RES_W-1:0]    fifo_dout;
  logic                fifo_empty;
  logic                fifo_full;
  logic                fifo_afull;
  logic [credit_w-1:0] credits;
  logic                send;
  node_result_t        out_res;

  assign send      = ~fifo_empty & (credits != '0);
  assign res_space = ~fifo_full & ~fifo_afull;     // Room for the results in flight

  sync_fifo #(
    .DATA_W (RES_W),
    .DEPTH  (OUT_DEPTH)
  ) u_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .din          (res_data),
    .push         (res_push),
    .pop          (send),
    .dout         (fifo_dout),
    .empty        (fifo_empty),
    .almost_empty (),
    .full         (fifo_full),
    .almost_full  (fifo_afull)
  );

  // Spend and return in one cycle cancel out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= credit_w'(OUT_CREDITS);
    end else if (send & ~out_credit) begin
      credits <= credits - 1'b1;
    end else if (out_credit & ~send) begin
      credits <= credits + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= send;
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      out_res <= fifo_dout;
    end
  end

  assign out_node_id   = out_res.node_id;
  assign out_count     = out_res.edge_count;
  assign out_max_score = out_res.max_score;

endmodule

// File: verilog/edge_score_unit.sv
// Record parser and two-stage attention score pipeline; emits count and max score per node
`timescale 1ns/1ps

module edge_score_unit import gat_types_pkg::*; #(
  parameter feat_word_t ATT_VEC = 32'h02FF_03FE  // {2, -1, 3, -2}
) (
  input  logic          clk,
  input  logic          rst_n,
  feat_stream_if.dst    fs,
  output logic          res_push,
  output node_result_t  res_data,
  input  logic          res_space
);

  logic [7:0]         remain;          // Edges of the current node still to take
  logic [7:0]         cur_node;
  logic               first_edge;
  logic               is_hdr;
  logic               zero_hdr;
  logic               hdr_take;
  logic               feat_take;
  logic               zero_load;

  logic               s1_vld;
  logic               s1_first;
  logic               s1_last;
  logic [7:0]         s1_node;
  logic signed [15:0] prod [4];

  score_t             sum;
  score_t             leaky;
  logic [7:0]         s2_node;
  logic [7:0]         run_cnt;
  score_t             run_max;
  logic               push_q;

  assign is_hdr   = (fs.kind == kind_hdr);
  assign zero_hdr = (fs.word.hdr.nbr_count == 8'd0);

  // An empty node would collide with an edge retiring from stage 1, so hold it one cycle
  assign fs.take   = res_space & ~(is_hdr & zero_hdr & s1_vld);
  assign hdr_take  = fs.avail & fs.take & is_hdr;
  assign feat_take = fs.avail & fs.take & ~is_hdr & (remain != 8'd0);  // Stray features drop
  assign zero_load = hdr_take & zero_hdr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      remain     <= '0;
      first_edge <= 1'b0;
    end else if (hdr_take) begin
      remain     <= fs.word.hdr.nbr_count;
      first_edge <= 1'b1;
    end else if (feat_take) begin
      remain     <= remain - 8'd1;
      first_edge <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_take) begin
      cur_node <= fs.word.hdr.node_id;
    end
  end

  // Stage 1 forms the four products
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld <= 1'b0;
    end else begin
      s1_vld <= feat_take;
    end
  end

  always_ff @(posedge clk) begin
    if (feat_take) begin
      s1_first <= first_edge;
      s1_last  <= (remain == 8'd1);
      s1_node  <= cur_node;
      for (int i = 0; i < 4; i++) begin
        prod[i] <= $signed(fs.word.feat[i]) * $signed(ATT_VEC[i]);
      end
    end
  end

  // Sum and LeakyReLU with slope 1/8
  always_comb begin
    sum   = prod[0] + prod[1] + prod[2] + prod[3];
    leaky = sum[17] ? (sum >>> 3) : sum;
  end

  // Stage 2 folds the score into the node's running state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push_q <= 1'b0;
    end else begin
      push_q <= zero_load | (s1_vld & s1_last);
    end
  end

  always_ff @(posedge clk) begin
    if (zero_load) begin
      s2_node <= fs.word.hdr.node_id;    // Empty node bypasses the pipeline
      run_cnt <= '0;
      run_max <= score_min;
    end else if (s1_vld) begin
      s2_node <= s1_node;
      if (s1_first) begin
        run_cnt <= 8'd1;
        run_max <= leaky;
      end else begin
        run_cnt <= run_cnt + 8'd1;
        run_max <= (leaky > run_max) ? leaky : run_max;
      end
    end
  end

  assign res_push = push_q;
  assign res_data = '{node_id: s2_node, edge_count: run_cnt, max_score: run_max};

endmodule

// File: verilog/feat_ingress.sv
// Input side: buffers upstream words and returns one credit per word handed to the scoring unit
`timescale 1ns/1ps

module feat_ingress import gat_types_pkg::*; #(
  parameter int IN_DEPTH = 8
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         in_valid,
  input  logic         in_kind,
  input  stream_word_u in_word,
  output logic         in_credit,
  feat_stream_if.src   fs
);

  logic [word_w:0] fifo_din;
  logic [word_w:0] fifo_dout;
  logic            fifo_empty;
  logic            consume;

  assign fifo_din = {in_kind, in_word};    // Kind bit rides above the word
  assign consume  = fs.avail & fs.take;

  sync_fifo #(
    .DATA_W (word_w + 1),
    .DEPTH  (IN_DEPTH)
  ) u_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .din          (fifo_din),
    .push         (in_valid),
    .pop          (consume),
    .dout         (fifo_dout),
    .empty        (fifo_empty),
    .almost_empty (),
    .full         (),
    .almost_full  ()
  );

  assign fs.avail = ~fifo_empty;
  assign fs.kind  = fifo_dout[word_w];
  assign fs.word  = fifo_dout[word_w-1:0];

  // Source never holds more than IN_DEPTH uncredited words, so the FIFO cannot overflow
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_credit <= 1'b0;
    end else begin
      in_credit <= consume;                // One pulse per consumed word
    end
  end

endmodule

// File: verilog/sync_fifo.sv
// Fall-through synchronous FIFO with near-empty and near-full flags, used by ingress and egress
`timescale 1ns/1ps

module sync_fifo import gat_flow_pkg::*; #(
  parameter int DATA_W = 32,
  parameter int DEPTH  = 8      // Power of two
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [DATA_W-1:0] din,
  input  logic              push,
  input  logic              pop,
  output logic [DATA_W-1:0] dout,
  output logic              empty,
  output logic              almost_empty,
  output logic              full,
  output logic              almost_full
);

  localparam int ADDR_W = $clog2(DEPTH);

  logic [DATA_W-1:0]  mem [DEPTH];
  logic [ADDR_W:0]    wr_ptr;          // Extra MSB is the wrap bit
  logic [ADDR_W:0]    rd_ptr;
  logic [ADDR_W:0]    ptr_diff;
  logic [level_w-1:0] level;
  logic               do_push;
  logic               do_pop;

  assign do_push = push & ~full;       // Push on full is dropped
  assign do_pop  = pop & ~empty;       // Pop on empty is dropped

  assign ptr_diff = wr_ptr - rd_ptr;   // Modulo the pointer width
  assign level    = level_w'(ptr_diff);

  assign empty        = (wr_ptr == rd_ptr);
  assign full         = (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]) &
                        (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]);
  assign almost_empty = (level == level_w'(1));          // One entry left
  assign almost_full  = (level == level_w'(DEPTH - 1));  // One slot left

  assign dout = mem[rd_ptr[ADDR_W-1:0]];                  // Head shown without a pop

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[ADDR_W-1:0]] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (do_push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (do_pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

// File: verilog/feat_stream_if.sv
// Word stream from the ingress buffer to the scoring unit; a word moves when avail and take are high
`timescale 1ns/1ps

interface feat_stream_if import gat_types_pkg::*; ();

  stream_word_u word;   // Head word of the ingress FIFO
  logic         kind;   // Header or feature
  logic         avail;  // Head word is valid
  logic         take;   // Consumer accepts the head word

  modport src (
    output word, kind, avail,
    input  take
  );

  modport dst (
    input  word, kind, avail,
    output take
  );

endinterface

// File: verilog/gat_flow_pkg.sv
// Counter widths for the credit and FIFO fill logic, imported where flow control is kept
package gat_flow_pkg;

  // Up to 16 outstanding credits
  localparam int credit_w = 5;

  // Fill level of a FIFO of up to 16 entries
  localparam int level_w = 5;

endpackage

// File: verilog/gat_types_pkg.sv
// Stream word and per-node result formats of the edge-scoring stage, imported by datapath and testbench
package gat_types_pkg;

  localparam int word_w = 32;           // One stream word

  localparam logic kind_hdr  = 1'b1;    // Kind bit for a header word
  localparam logic kind_feat = 1'b0;    // Kind bit for a feature word

  typedef logic signed [7:0] feat_t;

  typedef struct packed {
    logic [7:0]  node_id;
    logic [7:0]  nbr_count;             // Feature words that follow
    logic [15:0] reserved;
  } node_hdr_t;

  typedef feat_t [3:0] feat_word_t;     // Four features of one neighbor

  // Same 32 bits, read as header or as features depending on the kind bit
  typedef union packed {
    node_hdr_t  hdr;
    feat_word_t feat;
  } stream_word_u;

  typedef logic signed [17:0] score_t;

  localparam score_t score_min = 18'sh20000;  // Most negative score

  typedef struct packed {
    logic [7:0] node_id;
    logic [7:0] edge_count;
    score_t     max_score;
  } node_result_t;

endpackage
